//--- common/db_intf.sv
/*
 * State database port
 * Single request/ack access, read or write, one word per request
 */
`timescale 1ns/10ps
`default_nettype none

interface db_intf import state_pkg::*; ();

    // Request side, held until ack
    logic               req;
    logic               we;
    logic [ID_W-1:0]    id;
    logic [STATE_W-1:0] wdata;

    // Response side, ack is a single cycle
    logic               ack;
    // Valid with ack on reads
    logic [STATE_W-1:0] rdata;

    modport requester (output req, we, id, wdata, input ack, rdata);

    modport responder (input req, we, id, wdata, output ack, rdata);

endinterface : db_intf

`default_nettype wire

//--- common/state_pkg.sv
/*
 * State store package
 * Widths, control register map, update ops and the update word layout
 */
`default_nettype none

package state_pkg;

    // ----------------------------------------------------------
    // Widths and depth
    // ----------------------------------------------------------
    localparam int ID_W     = 8;
    localparam int NUM_IDS  = 256;
    localparam int STATE_W  = 32;
    // Merge mask and value each cover half a state word
    localparam int MERGE_W  = STATE_W / 2;
    localparam int WB_ADR_W = 2;

    // Control register word addresses
    localparam logic [WB_ADR_W-1:0] REG_CTRL    = 2'd0;
    localparam logic [WB_ADR_W-1:0] REG_COUNT   = 2'd1;
    localparam logic [WB_ADR_W-1:0] REG_RD_ID   = 2'd2;
    localparam logic [WB_ADR_W-1:0] REG_RD_DATA = 2'd3;

    // Update op bit
    localparam logic OP_SET   = 1'b0;
    localparam logic OP_MERGE = 1'b1;

    // Merge view, mask in the upper half and value in the lower half
    typedef struct packed {
        logic [MERGE_W-1:0] mask;
        logic [MERGE_W-1:0] value;
    } merge_word_t;

    // One update word, read through the view picked by the op bit
    typedef union packed {
        logic [STATE_W-1:0] set_val;
        merge_word_t        merge;
    } upd_word_u;

endpackage : state_pkg

`default_nettype wire

//--- common/state_update_intf.sv
/*
 * State update interface
 * Valid/ready transfer of one keyed update from the application to the core
 */
`timescale 1ns/10ps
`default_nettype none

interface state_update_intf import state_pkg::*; ();

    logic            valid;
    logic            ready;
    logic [ID_W-1:0] id;
    // OP_SET or OP_MERGE
    logic            op;
    upd_word_u       word;

    // Application side
    modport source (output valid, id, op, word, input ready);

    // Core side
    modport target (input valid, id, op, word, output ready);

endinterface : state_update_intf

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the state store simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_state_store \
    -f state_store.f \
    -o sim_state_store

output=$(./obj_dir/sim_state_store)
echo "$output"

if grep -qF '*** PASSED ***' <<< "$output"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi

//--- src/state_store_top.sv
/*
 * Keyed state store
 * Update port into a write-type state core, on-chip state database,
 * Wishbone control port for clear, count and readback
 */
`timescale 1ns/10ps
`default_nettype none

module state_store_top import state_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    // Application updates
    input  logic                upd_valid,
    output logic                upd_ready,
    input  logic                upd_op,
    input  logic [ID_W-1:0]     upd_id,
    input  logic [STATE_W-1:0]  upd_word,

    // Wishbone control
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [STATE_W-1:0]  wb_dat_w,
    output logic [STATE_W-1:0]  wb_dat_r,
    output logic                wb_ack
);

    logic db_init;
    logic init_done;
    logic applied;

    state_update_intf upd_if ();
    // Core side
    db_intf db_a ();
    // Control side
    db_intf db_b ();

    // Plain ports onto the update interface
    assign upd_if.valid = upd_valid;
    assign upd_if.op    = upd_op;
    assign upd_if.id    = upd_id;
    assign upd_if.word  = upd_word;
    assign upd_ready    = upd_if.ready;

    // ----------------------------------------------------------
    // Blocks
    // ----------------------------------------------------------
    state_write_core i_state_write_core (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .init_done ( init_done ),
        .update_if ( upd_if ),
        .db_if     ( db_a ),
        .applied   ( applied )
    );

    state_db i_state_db (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .db_init   ( db_init ),
        .init_done ( init_done ),
        .port_a    ( db_a ),
        .port_b    ( db_b )
    );

    wb_state_ctrl i_wb_state_ctrl (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .wb_cyc    ( wb_cyc ),
        .wb_stb    ( wb_stb ),
        .wb_we     ( wb_we ),
        .wb_adr    ( wb_adr ),
        .wb_dat_w  ( wb_dat_w ),
        .wb_dat_r  ( wb_dat_r ),
        .wb_ack    ( wb_ack ),
        .db_init   ( db_init ),
        .init_done ( init_done ),
        .applied   ( applied ),
        .db_if     ( db_b )
    );

endmodule : state_store_top

`default_nettype wire

//--- src/wb_state_ctrl.sv
/*
 * Wishbone control registers
 * Clear start and status, applied update count, state readback by id
 */
`timescale 1ns/10ps
`default_nettype none

module wb_state_ctrl import state_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    // Wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [STATE_W-1:0]  wb_dat_w,
    output logic [STATE_W-1:0]  wb_dat_r,
    output logic                wb_ack,

    // Clear control
    output logic                db_init,
    input  logic                init_done,

    // Pulse per committed update
    input  logic                applied,

    // Readback, port B
    db_intf.requester           db_if
);

    logic               stb_new;
    logic               rd_data_acc;
    logic               clr_cmd;
    logic               rd_req_q;
    logic               rd_done;
    logic [ID_W-1:0]    rd_id_q;
    logic [STATE_W-1:0] count_q;

    // ----------------------------------------------------------
    // Access decode
    // ----------------------------------------------------------
    // New cycle only, not one already acked or waiting on the db
    assign stb_new     = wb_cyc && wb_stb && !wb_ack && !rd_req_q;
    assign rd_data_acc = stb_new && !wb_we && (wb_adr == REG_RD_DATA);
    assign clr_cmd     = stb_new && wb_we && (wb_adr == REG_CTRL) && wb_dat_w[0];
    assign rd_done     = rd_req_q && db_if.ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            db_init  <= 1'b0;
            rd_req_q <= 1'b0;
            rd_id_q  <= '0;
            count_q  <= '0;
        end else begin
            db_init <= clr_cmd;
            // Plain registers ack next cycle, readback acks after db ack
            wb_ack  <= (stb_new && !rd_data_acc) || rd_done;
            if (rd_data_acc) begin
                rd_req_q <= 1'b1;
            end else if (rd_done) begin
                rd_req_q <= 1'b0;
            end
            if (stb_new && wb_we && (wb_adr == REG_RD_ID)) begin
                rd_id_q <= wb_dat_w[ID_W-1:0];
            end
            // A clear restarts the count
            if (clr_cmd) begin
                count_q <= '0;
            end else if (applied) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Read data
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rd_done) begin
            wb_dat_r <= db_if.rdata;
        end else if (stb_new) begin
            case (wb_adr)
                REG_CTRL:  wb_dat_r <= STATE_W'(init_done);
                REG_COUNT: wb_dat_r <= count_q;
                REG_RD_ID: wb_dat_r <= STATE_W'(rd_id_q);
                default:   wb_dat_r <= wb_dat_r;
            endcase
        end
    end

    // Port B is read only
    assign db_if.req   = rd_req_q;
    assign db_if.we    = 1'b0;
    assign db_if.id    = rd_id_q;
    assign db_if.wdata = '0;

endmodule : wb_state_ctrl

`default_nettype wire

//--- state_core/state_core.sv
/*
 * State core
 * Takes one update at a time, reads the previous state of its id,
 * hands it to the parent and writes back the state the parent returns
 */
`timescale 1ns/10ps
`default_nettype none

module state_core import state_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,

    // Database clear finished
    input  logic               init_done,

    // Update stream from the application
    state_update_intf.target   update_if,

    // Database access, port A
    db_intf.requester          db_if,

    // Previous state out, new state back from the parent
    output logic [STATE_W-1:0] prev_state,
    input  logic [STATE_W-1:0] new_state,

    // One pulse per committed write
    output logic               applied
);

    // ----------------------------------------------------------
    // Signals
    // ----------------------------------------------------------
    // Read of previous state outstanding
    logic               rd_phase;
    // Write of new state outstanding
    logic               wr_phase;
    logic               accept;
    logic               rd_done;
    logic               wr_done;
    logic [ID_W-1:0]    id_q;
    logic [STATE_W-1:0] wdata_q;

    // ----------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------
    // Only idle once the database is cleared
    assign update_if.ready = init_done && !rd_phase && !wr_phase;
    assign accept          = update_if.valid && update_if.ready;

    assign rd_done = rd_phase && db_if.ack;
    assign wr_done = wr_phase && db_if.ack;

    // ----------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------
    // Idle -> read -> write -> idle
    // The write request follows the read ack directly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_phase <= 1'b0;
            wr_phase <= 1'b0;
        end else begin
            if (accept) begin
                rd_phase <= 1'b1;
            end else if (rd_done) begin
                rd_phase <= 1'b0;
                wr_phase <= 1'b1;
            end else if (wr_done) begin
                wr_phase <= 1'b0;
            end
        end
    end

    // Update id, and the new state computed in the read ack cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            id_q <= update_if.id;
        end
        if (rd_done) begin
            wdata_q <= new_state;
        end
    end

    // ----------------------------------------------------------
    // Database port
    // ----------------------------------------------------------
    assign db_if.req   = rd_phase || wr_phase;
    assign db_if.we    = wr_phase;
    assign db_if.id    = id_q;
    assign db_if.wdata = wdata_q;

    // Read data is only meaningful in the read ack cycle
    assign prev_state = db_if.rdata;

    // Commit seen on the write ack
    assign applied = wr_done;

endmodule : state_core

`default_nettype wire

//--- state_core/state_write_core.sv
/*
 * Write-type state core
 * SET overwrites the state, MERGE replaces the masked bits of the low half
 */
`timescale 1ns/10ps
`default_nettype none

module state_write_core import state_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             init_done,
    state_update_intf.target update_if,
    db_intf.requester        db_if,
    output logic             applied
);

    logic               op_q;
    upd_word_u          word_q;
    logic [STATE_W-1:0] prev_state;
    logic [STATE_W-1:0] new_state;
    logic [MERGE_W-1:0] merged_lo;

    // Op and word captured on the same handshake the core accepts
    always_ff @(posedge clk) begin
        if (update_if.valid && update_if.ready) begin
            op_q   <= update_if.op;
            word_q <= update_if.word;
        end
    end

    // ----------------------------------------------------------
    // New state
    // ----------------------------------------------------------
    // Mask bit set takes the value bit, else keep the previous bit
    assign merged_lo = (prev_state[MERGE_W-1:0] & ~word_q.merge.mask)
                     | (word_q.merge.value & word_q.merge.mask);

    always_comb begin
        case (op_q)
            OP_SET:   new_state = word_q.set_val;
            // Upper half untouched by a merge
            OP_MERGE: new_state = {prev_state[STATE_W-1:MERGE_W], merged_lo};
            default:  new_state = word_q.set_val;
        endcase
    end

    // Read, sequence and write back
    state_core i_state_core (
        .clk        ( clk ),
        .rst_n      ( rst_n ),
        .init_done  ( init_done ),
        .update_if  ( update_if ),
        .db_if      ( db_if ),
        .prev_state ( prev_state ),
        .new_state  ( new_state ),
        .applied    ( applied )
    );

endmodule : state_write_core

`default_nettype wire

//--- state_db/state_db.sv
/*
 * State database
 * 256 x 32 state memory with two request ports and a zero-fill sweep
 * Port B wins when both ports request in the same cycle
 */
`timescale 1ns/10ps
`default_nettype none

module state_db import state_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       db_init,
    output logic       init_done,
    db_intf.responder  port_a,
    db_intf.responder  port_b
);

    logic [STATE_W-1:0] mem [NUM_IDS];
    // Sweep in progress, set out of reset
    logic               clearing;
    logic [ID_W-1:0]    clr_addr;
    logic               sel_a;
    logic               sel_b;
    logic               ack_a_q;
    logic               ack_b_q;
    logic [STATE_W-1:0] rdata_a_q;
    logic [STATE_W-1:0] rdata_b_q;

    // ----------------------------------------------------------
    // Arbitration
    // ----------------------------------------------------------
    // A request still high in its ack cycle is not served twice
    assign sel_b = !clearing && port_b.req && !ack_b_q;
    assign sel_a = !clearing && port_a.req && !ack_a_q && !sel_b;

    // ----------------------------------------------------------
    // Clear sweep and acks
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clearing <= 1'b1;
            clr_addr <= '0;
            ack_a_q  <= 1'b0;
            ack_b_q  <= 1'b0;
        end else begin
            ack_a_q <= sel_a;
            ack_b_q <= sel_b;
            if (db_init) begin
                clearing <= 1'b1;
                clr_addr <= '0;
            end else if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                // Last entry, one per cycle over the whole depth
                if (clr_addr == ID_W'(NUM_IDS - 1)) begin
                    clearing <= 1'b0;
                end
            end
        end
    end

    // Single write port, shared by the sweep and both requesters
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_addr] <= '0;
        end else if (sel_b && port_b.we) begin
            mem[port_b.id] <= port_b.wdata;
        end else if (sel_a && port_a.we) begin
            mem[port_a.id] <= port_a.wdata;
        end
        if (sel_a) begin
            rdata_a_q <= mem[port_a.id];
        end
        if (sel_b) begin
            rdata_b_q <= mem[port_b.id];
        end
    end

    assign port_a.ack   = ack_a_q;
    assign port_a.rdata = rdata_a_q;
    assign port_b.ack   = ack_b_q;
    assign port_b.rdata = rdata_b_q;
    assign init_done    = !clearing;

endmodule : state_db

`default_nettype wire

//--- state_store.f
common/state_pkg.sv
common/state_update_intf.sv
common/db_intf.sv
state_core/state_core.sv
state_core/state_write_core.sv
state_db/state_db.sv
src/wb_state_ctrl.sv
src/state_store_top.sv
verif/tb_state_store.sv

//--- verif/tb_state_store.sv
/*
 * Testbench for the keyed state store
 * Random SET and MERGE updates checked against a reference model,
 * Wishbone readback, port contention and database clear
 */
`timescale 1ns/10ps
`default_nettype none

module tb_state_store import state_pkg::*; ();

    // ----------------------------------------------------------
    // Test lengths and run limit
    // ----------------------------------------------------------
    localparam int RST_CYCLES     = 8;
    localparam int SWEEP_CYCLES   = NUM_IDS;
    // Worst case for one Wishbone access or one update
    localparam int TXN_CYCLES     = 10;
    localparam int N_ZERO_READS   = 16;
    localparam int N_UPDATES      = 200;
    localparam int N_CONT_UPDATES = 100;
    // Small id window so that ids repeat
    localparam logic [ID_W-1:0] ID_BASE = 8'h40;
    localparam int ID_RANGE       = 16;
    localparam int WORST_CYCLES   = RST_CYCLES + 2 * SWEEP_CYCLES + TXN_CYCLES
        * (2 * N_ZERO_READS + 3 * N_UPDATES + 4 * N_CONT_UPDATES + 4 * ID_RANGE + 8);
    localparam int CYCLE_LIMIT    = 2 * WORST_CYCLES;

    logic                clk;
    logic                rst_n;
    logic                upd_valid;
    logic                upd_ready;
    logic                upd_op;
    logic [ID_W-1:0]     upd_id;
    logic [STATE_W-1:0]  upd_word;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [STATE_W-1:0]  wb_dat_w;
    logic [STATE_W-1:0]  wb_dat_r;
    logic                wb_ack;

    // Reference model and bookkeeping
    logic [STATE_W-1:0]  model_mem [NUM_IDS];
    logic                touched [NUM_IDS];
    int                  model_count;
    logic [31:0]         lfsr_q;
    int                  num_checks;
    int                  num_errors;
    int                  cycle_count;

    state_store_top dut_i (
        .clk       ( clk ),
        .rst_n     ( rst_n ),
        .upd_valid ( upd_valid ),
        .upd_ready ( upd_ready ),
        .upd_op    ( upd_op ),
        .upd_id    ( upd_id ),
        .upd_word  ( upd_word ),
        .wb_cyc    ( wb_cyc ),
        .wb_stb    ( wb_stb ),
        .wb_we     ( wb_we ),
        .wb_adr    ( wb_adr ),
        .wb_dat_w  ( wb_dat_w ),
        .wb_dat_r  ( wb_dat_r ),
        .wb_ack    ( wb_ack )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit counted on every rising edge
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    // ----------------------------------------------------------
    // Random bits, model and checks
    // ----------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // SET takes the word, MERGE writes masked low bits and keeps the high half
    function automatic logic [STATE_W-1:0] model_apply(input logic op,
            input logic [STATE_W-1:0] prev, input logic [STATE_W-1:0] word);
        logic [15:0] mask;
        logic [15:0] value;
        mask  = word[31:16];
        value = word[15:0];
        if (op == OP_SET) begin
            return word;
        end
        return {prev[31:16], (prev[15:0] & ~mask) | (value & mask)};
    endfunction

    task automatic check_value(input string name, input logic [STATE_W-1:0] exp,
            input logic [STATE_W-1:0] act);
        num_checks++;
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
            num_errors++;
        end
    endtask

    // Two results are acceptable when a read races a write
    task automatic check_either(input string name, input logic [STATE_W-1:0] exp_a,
            input logic [STATE_W-1:0] exp_b, input logic [STATE_W-1:0] act);
        num_checks++;
        assert (act === exp_a || act === exp_b) else begin
            $display("[ERROR] %s: expected %08h or %08h, actual %08h",
                     name, exp_a, exp_b, act);
            num_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        num_checks++;
        assert (cond) else begin
            $display("[ERROR] %s", what);
            num_errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (num_errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: fail, %0d errors", name, num_errors - err_start);
        end
    endtask

    // ----------------------------------------------------------
    // Bus tasks that start and end on a falling edge
    // ----------------------------------------------------------
    // ready_snap is upd_ready in the cycle the DUT samples the access
    task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
            input logic [STATE_W-1:0] wdata, output logic [STATE_W-1:0] rdata,
            output logic ready_snap);
        wb_cyc     = 1'b1;
        wb_stb     = 1'b1;
        wb_we      = we;
        wb_adr     = adr;
        wb_dat_w   = wdata;
        ready_snap = upd_ready;
        do @(negedge clk); while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // One idle cycle between accesses
        @(negedge clk);
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [STATE_W-1:0] data);
        logic [STATE_W-1:0] unused_rd;
        logic               unused_rdy;
        wb_access(1'b1, adr, data, unused_rd, unused_rdy);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [STATE_W-1:0] data,
            output logic ready_snap);
        wb_access(1'b0, adr, '0, data, ready_snap);
    endtask

    task automatic read_state(input logic [ID_W-1:0] id, output logic [STATE_W-1:0] data);
        logic snap;
        wb_write(REG_RD_ID, STATE_W'(id));
        wb_read(REG_RD_DATA, data, snap);
    endtask

    // Transfer on the rising edge where valid and ready are both high
    task automatic send_update(input logic op, input logic [ID_W-1:0] id,
            input logic [STATE_W-1:0] word);
        upd_valid = 1'b1;
        upd_op    = op;
        upd_id    = id;
        upd_word  = word;
        while (!upd_ready) @(negedge clk);
        @(posedge clk);
        @(negedge clk);
        upd_valid = 1'b0;
        model_mem[id] = model_apply(op, model_mem[id], word);
        touched[id]   = 1'b1;
        model_count++;
    endtask

    // Ready returns once the write back is acknowledged
    task automatic wait_update_idle();
        while (!upd_ready) @(negedge clk);
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        logic [STATE_W-1:0] rdata;
        logic [STATE_W-1:0] word;
        logic [STATE_W-1:0] old_val;
        logic [ID_W-1:0]    id;
        logic               op;
        logic               snap;
        int                 err_start;
        int                 polls;
        int                 delay;

        rst_n = 1'b0;
        upd_valid = 1'b0;
        upd_op = 1'b0;
        upd_id = '0;
        upd_word = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        lfsr_q = 32'h2ca381e4;
        num_checks = 0;
        num_errors = 0;
        model_count = 0;
        for (int i = 0; i < NUM_IDS; i++) begin
            model_mem[i] = '0;
            touched[i]   = 1'b0;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Test 1 checks that the database reads zero once the reset sweep is done
        err_start = num_errors;
        do wb_read(REG_CTRL, rdata, snap); while (!rdata[0]);
        for (int i = 0; i < N_ZERO_READS; i++) begin
            id = ID_W'(rand_bits(ID_W));
            read_state(id, rdata);
            check_value("zero after reset", '0, rdata);
        end
        report_test("test 1 zero after reset", err_start);

        // Test 2 sends SET and MERGE on a small id window with readback after each
        err_start = num_errors;
        for (int i = 0; i < N_UPDATES; i++) begin
            op   = rand_bits(1) != 0;
            id   = ID_BASE + ID_W'(rand_bits(4));
            word = rand_bits(STATE_W);
            send_update(op, id, word);
            wait_update_idle();
            read_state(id, rdata);
            check_value("update readback", model_mem[id], rdata);
        end
        report_test("test 2 random updates", err_start);

        // Test 3 reads the applied count since the reset clear
        err_start = num_errors;
        wb_read(REG_COUNT, rdata, snap);
        check_value("update count", STATE_W'(model_count), rdata);
        report_test("test 3 update count", err_start);

        // Test 4 lets the readback race the update on the same id
        err_start = num_errors;
        for (int i = 0; i < N_CONT_UPDATES; i++) begin
            op    = rand_bits(1) != 0;
            id    = ID_BASE + ID_W'(rand_bits(4));
            word  = rand_bits(STATE_W);
            delay = int'(rand_bits(2));
            old_val = model_mem[id];
            wb_write(REG_RD_ID, STATE_W'(id));
            send_update(op, id, word);
            repeat (delay) @(negedge clk);
            wb_read(REG_RD_DATA, rdata, snap);
            // Either side of the write back is a valid result
            check_either("readback during update", old_val, model_mem[id], rdata);
        end
        wait_update_idle();
        for (int i = 0; i < ID_RANGE; i++) begin
            id = ID_BASE + ID_W'(i);
            read_state(id, rdata);
            check_value("final readback", model_mem[id], rdata);
        end
        wb_read(REG_COUNT, rdata, snap);
        check_value("count after contention", STATE_W'(model_count), rdata);
        report_test("test 4 port contention", err_start);

        // Test 5 clears the database through REG_CTRL
        err_start = num_errors;
        wb_write(REG_CTRL, 32'h1);
        model_count = 0;
        for (int i = 0; i < NUM_IDS; i++) begin
            model_mem[i] = '0;
        end
        polls = 0;
        do begin
            wb_read(REG_CTRL, rdata, snap);
            if (!rdata[0]) begin
                polls++;
                check_true(!snap, "upd_ready is high while the clear is running");
            end
        end while (!rdata[0]);
        check_true(polls > 0, "REG_CTRL bit 0 never read zero after the clear started");
        wb_read(REG_COUNT, rdata, snap);
        check_value("count after clear", '0, rdata);
        for (int i = 0; i < NUM_IDS; i++) begin
            if (touched[i]) begin
                read_state(ID_W'(i), rdata);
                check_value("state after clear", '0, rdata);
            end
        end
        report_test("test 5 clear", err_start);

        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_state_store

`default_nettype wire
